// ==== hdl/ccm_pkg.sv ====
package ccm_pkg;

   // address map
   localparam logic [31:0] CCM_BASE = 32'hF004_0000;   // memory window, 256 bytes
   localparam logic [31:0] REG_BASE = 32'hF004_1000;   // register window, two words
   localparam int REGION_BITS = 4;                     // top address bits that pick a region
   localparam int CCM_WIN_BITS = 8;                    // log2 of the memory window size
   localparam int REG_WIN_BITS = 3;                    // log2 of the register window size

   // register offsets inside the register window
   localparam logic [2:0] REG_INJECT_OFS = 3'h0;
   localparam logic [2:0] REG_STATUS_OFS = 3'h4;

   localparam int CCM_DEPTH = 64;
   localparam int CODEWORD_BITS = 39;   // 32 data + 6 hamming + overall parity

   typedef logic [31:0] word_t;
   typedef logic [31:0] addr_t;
   typedef logic [6:0] ecc_t;           // bit 6 is overall parity
   typedef logic [CODEWORD_BITS-1:0] codeword_t;
   typedef logic [$clog2(CCM_DEPTH)-1:0] index_t;
   typedef logic [15:0] count_t;

   // inject register fields
   localparam int INJ_SINGLE_BIT = 8;
   localparam int INJ_DOUBLE_BIT = 9;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_READ_WAIT
   } apb_state_t;

endpackage

// ==== hdl/secded_encode.sv ====
`timescale 1ns/1ps

module secded_encode (
   input  ccm_pkg::word_t data,
   output ccm_pkg::ecc_t  ecc
);

   logic [5:0] check;

   // each check bit covers the data bits whose hamming position has that bit set
   assign check[0] = ^(data & 32'h56AA_AD5B);   // positions 3,5,7,9,...
   assign check[1] = ^(data & 32'h9B33_366D);   // positions 3,6,7,10,11,...
   assign check[2] = ^(data & 32'hE3C3_C78E);
   assign check[3] = ^(data & 32'h03FC_07F0);   // positions 9-15, 24-31
   assign check[4] = ^(data & 32'h03FF_F800);   // positions 17-31
   assign check[5] = ^(data & 32'hFC00_0000);   // positions 33-38

   // overall parity over data and check bits, so a clean codeword xors to zero
   assign ecc = {(^data) ^ (^check), check};

endmodule

// ==== hdl/secded_decode.sv ====
`timescale 1ns/1ps

module secded_decode (
   input  ccm_pkg::codeword_t codeword,
   output ccm_pkg::word_t     data,
   output logic               single_err,
   output logic               double_err
);

   logic [5:0]         syndrome;
   logic               parity_err;
   ccm_pkg::codeword_t flip_mask;
   ccm_pkg::codeword_t fixed;

   // syndrome is the xor of the positions of all set bits, parity bit excluded
   always_comb begin
      syndrome = '0;
      for (int i = 0; i < ccm_pkg::CODEWORD_BITS - 1; i++) begin
         if (codeword[i]) begin
            syndrome = syndrome ^ 6'(i + 1);
         end
      end
   end

   assign parity_err = ^codeword;   // odd number of flipped bits

   // odd flips with any syndrome is taken as one error
   assign single_err = parity_err;
   assign double_err = ~parity_err & (syndrome != 6'd0);

   // one-hot at the failing position; zero syndrome points at the parity bit
   always_comb begin
      flip_mask = '0;
      for (int i = 0; i < ccm_pkg::CODEWORD_BITS - 1; i++) begin
         flip_mask[i] = (syndrome == 6'(i + 1));
      end
      flip_mask[ccm_pkg::CODEWORD_BITS-1] = (syndrome == 6'd0);
   end

   // double errors pass through uncorrected
   assign fixed = single_err ? (codeword ^ flip_mask) : codeword;

   // drop the check bits at positions 1,2,4,8,16,32 and the parity bit at 39
   assign data = {fixed[37:32],
                  fixed[30:16],
                  fixed[14:8],
                  fixed[6:4],
                  fixed[2]};

endmodule

// ==== hdl/ccm_array.sv ====
`timescale 1ns/1ps

module ccm_array (
   input  logic               clk,
   input  logic               rst_l,
   input  logic               wr_en,
   input  ccm_pkg::index_t    wr_index,
   input  ccm_pkg::codeword_t wr_word,
   input  logic               rd_en,
   input  ccm_pkg::index_t    rd_index,
   output ccm_pkg::codeword_t rd_word
);

   ccm_pkg::codeword_t mem [ccm_pkg::CCM_DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_index] <= wr_word;
      end
   end

   // read data register, only loads on a read so the word holds afterwards
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         rd_word <= '0;
      end else if (rd_en) begin
         rd_word <= mem[rd_index];
      end
   end

endmodule

// ==== hdl/ccm_apb_ctrl.sv ====
`timescale 1ns/1ps

module ccm_apb_ctrl (
   input  logic               clk,
   input  logic               rst_l,
   // apb completer
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  ccm_pkg::addr_t     paddr,
   input  ccm_pkg::word_t     pwdata,
   output logic               pready,
   output ccm_pkg::word_t     prdata,
   output logic               pslverr,
   // encoder
   output ccm_pkg::word_t     wr_data,
   input  ccm_pkg::ecc_t      wr_ecc,
   // array
   output logic               wr_en,
   output ccm_pkg::index_t    wr_index,
   output ccm_pkg::codeword_t wr_word,
   output logic               rd_en,
   output ccm_pkg::index_t    rd_index,
   // decoder
   input  ccm_pkg::word_t     rd_data,
   input  logic               single_err,
   input  logic               double_err
);

   localparam int RB = 32 - ccm_pkg::REGION_BITS;   // lowest region bit

   ccm_pkg::apb_state_t state, state_nxt;

   logic               acc_phase;
   logic               mem_region, mem_range, reg_region, reg_range;
   logic               aligned;
   logic               mem_sel, inj_sel, sta_sel, addr_ok;
   logic               mem_rd;
   logic [5:0]         inj_pos;
   logic               inj_single, inj_double;
   ccm_pkg::word_t     inject_rd;
   ccm_pkg::codeword_t flip_mask;
   ccm_pkg::codeword_t enc_word;
   ccm_pkg::count_t    single_cnt, double_cnt;

   assign acc_phase = (state == ccm_pkg::ST_ACCESS) & psel & penable;

   // region compare on the top bits, then a range compare below it per window
   assign mem_region = paddr[31:RB] == ccm_pkg::CCM_BASE[31:RB];
   assign mem_range  = paddr[RB-1:ccm_pkg::CCM_WIN_BITS] ==
                       ccm_pkg::CCM_BASE[RB-1:ccm_pkg::CCM_WIN_BITS];
   assign reg_region = paddr[31:RB] == ccm_pkg::REG_BASE[31:RB];
   assign reg_range  = paddr[RB-1:ccm_pkg::REG_WIN_BITS] ==
                       ccm_pkg::REG_BASE[RB-1:ccm_pkg::REG_WIN_BITS];
   assign aligned    = paddr[1:0] == 2'b00;

   assign mem_sel = mem_region & mem_range & aligned;
   assign inj_sel = reg_region & reg_range &
                    (paddr[ccm_pkg::REG_WIN_BITS-1:0] == ccm_pkg::REG_INJECT_OFS);
   assign sta_sel = reg_region & reg_range &
                    (paddr[ccm_pkg::REG_WIN_BITS-1:0] == ccm_pkg::REG_STATUS_OFS);
   assign addr_ok = mem_sel | inj_sel | sta_sel;

   assign mem_rd = acc_phase & mem_sel & ~pwrite;

   always_comb begin
      state_nxt = state;
      case (state)
         ccm_pkg::ST_IDLE:
            if (psel && !penable) begin
               state_nxt = ccm_pkg::ST_ACCESS;   // setup seen
            end
         ccm_pkg::ST_ACCESS:
            state_nxt = mem_rd ? ccm_pkg::ST_READ_WAIT : ccm_pkg::ST_IDLE;
         default:
            state_nxt = ccm_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         state <= ccm_pkg::ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // only memory reads take the extra cycle
   assign pready  = (acc_phase & ~mem_rd) | (state == ccm_pkg::ST_READ_WAIT);
   assign pslverr = (acc_phase & ~addr_ok) | ((state == ccm_pkg::ST_READ_WAIT) & double_err);

   // array and encoder side
   assign wr_data  = pwdata;
   assign wr_en    = acc_phase & mem_sel & pwrite;
   assign wr_index = paddr[ccm_pkg::CCM_WIN_BITS-1:2];
   assign rd_en    = mem_rd;
   assign rd_index = paddr[ccm_pkg::CCM_WIN_BITS-1:2];

   // hamming order, check bits at powers of two, parity on top
   assign enc_word = {wr_ecc[6], pwdata[31:26], wr_ecc[5], pwdata[25:11], wr_ecc[4],
                      pwdata[10:4], wr_ecc[3], pwdata[3:1], wr_ecc[2], pwdata[0],
                      wr_ecc[1:0]};
   assign wr_word  = enc_word ^ flip_mask;

   // position p is bit p-1; a double flip also hits p+1
   always_comb begin
      flip_mask = '0;
      for (int i = 0; i < ccm_pkg::CODEWORD_BITS; i++) begin
         if ((inj_single || inj_double) && inj_pos == 6'(i + 1)) begin
            flip_mask[i] = 1'b1;
         end
         if (inj_double && i > 0 && inj_pos == 6'(i)) begin
            flip_mask[i] = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         inj_pos    <= '0;
         inj_single <= 1'b0;
         inj_double <= 1'b0;
      end else if (wr_en) begin
         inj_pos    <= '0;      // one shot, gone after the next memory write
         inj_single <= 1'b0;
         inj_double <= 1'b0;
      end else if (acc_phase && pwrite && inj_sel) begin
         inj_pos    <= pwdata[5:0];
         inj_single <= pwdata[ccm_pkg::INJ_SINGLE_BIT];
         inj_double <= pwdata[ccm_pkg::INJ_DOUBLE_BIT];
      end
   end

   assign inject_rd = {22'd0, inj_double, inj_single, 2'b00, inj_pos};

   // error counters, saturating
   always_ff @(posedge clk or negedge rst_l) begin
      if (!rst_l) begin
         single_cnt <= '0;
         double_cnt <= '0;
      end else if (acc_phase && pwrite && sta_sel) begin
         single_cnt <= '0;
         double_cnt <= '0;
      end else if (state == ccm_pkg::ST_READ_WAIT) begin
         if (single_err && single_cnt != '1) begin
            single_cnt <= single_cnt + 1'b1;
         end
         if (double_err && double_cnt != '1) begin
            double_cnt <= double_cnt + 1'b1;
         end
      end
   end

   // read data, zero unless a register or memory read completes
   always_comb begin
      prdata = '0;
      if (state == ccm_pkg::ST_READ_WAIT) begin
         prdata = rd_data;
      end else if (acc_phase && !pwrite) begin
         if (inj_sel) begin
            prdata = inject_rd;
         end else if (sta_sel) begin
            prdata = {double_cnt, single_cnt};
         end
      end
   end

endmodule

// ==== hdl/ccm_top.sv ====
`timescale 1ns/1ps

module ccm_top (
   input  logic           clk,
   input  logic           rst_l,
   input  logic           psel,
   input  logic           penable,
   input  logic           pwrite,
   input  ccm_pkg::addr_t paddr,
   input  ccm_pkg::word_t pwdata,
   output logic           pready,
   output ccm_pkg::word_t prdata,
   output logic           pslverr
);

   ccm_pkg::word_t     wr_data;
   ccm_pkg::ecc_t      wr_ecc;
   logic               wr_en;
   ccm_pkg::index_t    wr_index;
   ccm_pkg::codeword_t wr_word;
   logic               rd_en;
   ccm_pkg::index_t    rd_index;
   ccm_pkg::codeword_t rd_word;
   ccm_pkg::word_t     rd_data;
   logic               single_err;
   logic               double_err;

   ccm_apb_ctrl ccm_apb_ctrl_inst (
      .clk        (clk),
      .rst_l      (rst_l),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .pready     (pready),
      .prdata     (prdata),
      .pslverr    (pslverr),
      .wr_data    (wr_data),
      .wr_ecc     (wr_ecc),
      .wr_en      (wr_en),
      .wr_index   (wr_index),
      .wr_word    (wr_word),
      .rd_en      (rd_en),
      .rd_index   (rd_index),
      .rd_data    (rd_data),
      .single_err (single_err),
      .double_err (double_err)
   );

   secded_encode secded_encode_inst (
      .data (wr_data),
      .ecc  (wr_ecc)
   );

   ccm_array ccm_array_inst (
      .clk      (clk),
      .rst_l    (rst_l),
      .wr_en    (wr_en),
      .wr_index (wr_index),
      .wr_word  (wr_word),
      .rd_en    (rd_en),
      .rd_index (rd_index),
      .rd_word  (rd_word)
   );

   // decode sits after the read register, result used in read_wait
   secded_decode secded_decode_inst (
      .codeword   (rd_word),
      .data       (rd_data),
      .single_err (single_err),
      .double_err (double_err)
   );

endmodule

// ==== verification/ccm_tb_tasks.svh ====
// apb master side of one transfer, setup then access until pready
task automatic apb_transfer(input logic write, input ccm_pkg::addr_t addr,
                            input ccm_pkg::word_t wdata, output ccm_pkg::word_t rdata,
                            output logic err, output int waits);
   @(posedge clk);
   psel    <= 1'b1;
   penable <= 1'b0;
   pwrite  <= write;
   paddr   <= addr;
   pwdata  <= wdata;
   @(posedge clk);
   penable <= 1'b1;
   @(negedge clk);            // sample away from the active edge
   waits = 0;
   while (!pready) begin
      waits++;                // access cycles without pready
      @(negedge clk);
   end
   rdata = prdata;
   err   = pslverr;
   @(posedge clk);
   psel    <= 1'b0;
   penable <= 1'b0;
endtask

task automatic check_value(input string name, input ccm_pkg::word_t expected,
                           input ccm_pkg::word_t actual);
   check_count++;
   if (expected !== actual) begin
      error_count++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
   end
endtask

function automatic logic is_check_pos(input int pos);
   return (pos & (pos - 1)) == 0;   // powers of two
endfunction

// data bits fill the free positions from 3 upward
// check bit 2^b is the parity of every position with bit b set
function automatic ccm_pkg::codeword_t ecc_encode(input ccm_pkg::word_t data);
   ccm_pkg::codeword_t cw;
   logic [5:0]         syn;
   int                 pos;
   int                 k;
   cw  = '0;
   syn = '0;
   k   = 0;
   for (pos = 1; pos < ccm_pkg::CODEWORD_BITS; pos++) begin
      if (!is_check_pos(pos)) begin
         cw[pos-1] = data[k];
         if (data[k]) begin
            syn = syn ^ 6'(pos);
         end
         k++;
      end
   end
   for (k = 0; k < 6; k++) begin
      cw[(1 << k) - 1] = syn[k];
   end
   cw[ccm_pkg::CODEWORD_BITS-1] = ^cw[ccm_pkg::CODEWORD_BITS-2:0];   // overall parity
   return cw;
endfunction

function automatic ccm_pkg::word_t ecc_decode(input ccm_pkg::codeword_t stored,
                                              output logic single_err,
                                              output logic double_err);
   ccm_pkg::codeword_t cw;
   ccm_pkg::word_t     data;
   logic [5:0]         syn;
   int                 pos;
   int                 k;
   cw  = stored;
   syn = '0;
   k   = 0;
   for (pos = 1; pos < ccm_pkg::CODEWORD_BITS; pos++) begin
      if (cw[pos-1]) begin
         syn = syn ^ 6'(pos);
      end
   end
   single_err = ^cw;
   double_err = !single_err && (syn != 6'd0);
   if (single_err) begin
      if (syn == 6'd0) begin
         cw[ccm_pkg::CODEWORD_BITS-1] = ~cw[ccm_pkg::CODEWORD_BITS-1];   // parity bit itself
      end else begin
         cw[syn-1] = ~cw[syn-1];
      end
   end
   for (pos = 1; pos < ccm_pkg::CODEWORD_BITS; pos++) begin
      if (!is_check_pos(pos)) begin
         data[k] = cw[pos-1];
         k++;
      end
   end
   return data;
endfunction

// flips that the inject register applies to the next stored word
function automatic ccm_pkg::codeword_t inject_mask(input ccm_pkg::word_t inj);
   ccm_pkg::codeword_t m;
   int                 p;
   m = '0;
   p = inj[5:0];
   if (inj[9]) begin
      m[p-1] = 1'b1;
      m[p]   = 1'b1;
   end else if (inj[8]) begin
      m[p-1] = 1'b1;
   end
   return m;
endfunction

// ==== verification/tb_ccm_top.sv ====
`timescale 1ns/1ps

module tb_ccm_top;

   typedef struct {
      int             test;
      logic           write;
      ccm_pkg::addr_t addr;
      ccm_pkg::word_t wdata;
      ccm_pkg::word_t exp_rdata;
      logic           exp_err;
      int             exp_waits;
   } row_t;

   localparam int KIND_MEM = 0;
   localparam int KIND_INJ = 1;
   localparam int KIND_STA = 2;
   localparam int KIND_BAD = 3;
   localparam ccm_pkg::addr_t INJECT_ADDR = ccm_pkg::REG_BASE + 32'(ccm_pkg::REG_INJECT_OFS);
   localparam ccm_pkg::addr_t STATUS_ADDR = ccm_pkg::REG_BASE + 32'(ccm_pkg::REG_STATUS_OFS);

   logic           clk;
   logic           rst_l;
   logic           psel;
   logic           penable;
   logic           pwrite;
   ccm_pkg::addr_t paddr;
   ccm_pkg::word_t pwdata;
   logic           pready;
   ccm_pkg::word_t prdata;
   logic           pslverr;

   row_t               rows[$];
   string              test_name[1:6];
   ccm_pkg::codeword_t mem_model [ccm_pkg::CCM_DEPTH];   // expected array contents
   ccm_pkg::word_t     inj_model;
   ccm_pkg::count_t    cnt_single;
   ccm_pkg::count_t    cnt_double;
   integer             seed;
   int                 check_count;
   int                 error_count;
   int                 cycle_count;
   int                 cycle_limit;

   `include "ccm_tb_tasks.svh"

   ccm_top ccm_top_inst (
      .clk     (clk),
      .rst_l   (rst_l),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .pready  (pready),
      .prdata  (prdata),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int addr_kind(input ccm_pkg::addr_t addr);
      if (addr[31:8] == ccm_pkg::CCM_BASE[31:8] && addr[1:0] == 2'b00) begin
         return KIND_MEM;
      end else if (addr == INJECT_ADDR) begin
         return KIND_INJ;
      end else if (addr == STATUS_ADDR) begin
         return KIND_STA;
      end
      return KIND_BAD;
   endfunction

   function automatic ccm_pkg::addr_t mem_addr(input int idx);
      return ccm_pkg::CCM_BASE + 32'(idx * 4);
   endfunction

   // each add_ call steps the reference model and appends one table row
   task automatic add_write(input int test, input ccm_pkg::addr_t addr,
                            input ccm_pkg::word_t data);
      row_t r;
      r = '{test, 1'b1, addr, data, 32'd0, addr_kind(addr) == KIND_BAD, 0};
      case (addr_kind(addr))
         KIND_MEM: begin
            mem_model[addr[7:2]] = ecc_encode(data) ^ inject_mask(inj_model);
            inj_model = '0;                    // one shot
         end
         KIND_INJ: inj_model = data & 32'h0000_033F;
         KIND_STA: begin
            cnt_single = '0;
            cnt_double = '0;
         end
         default: ;
      endcase
      rows.push_back(r);
   endtask

   task automatic add_read(input int test, input ccm_pkg::addr_t addr);
      row_t r;
      logic single_err;
      logic double_err;
      r = '{test, 1'b0, addr, 32'd0, 32'd0, 1'b0, 0};
      case (addr_kind(addr))
         KIND_MEM: begin
            r.exp_rdata = ecc_decode(mem_model[addr[7:2]], single_err, double_err);
            r.exp_err   = double_err;
            r.exp_waits = 1;                // array read needs one wait state
            if (single_err && cnt_single != '1) cnt_single++;
            if (double_err && cnt_double != '1) cnt_double++;
         end
         KIND_INJ: r.exp_rdata = inj_model;
         KIND_STA: r.exp_rdata = {cnt_double, cnt_single};
         default:  r.exp_err = 1'b1;        // rejected, data stays zero
      endcase
      rows.push_back(r);
   endtask

   task automatic add_mem_write(input int test, input int idx);
      add_write(test, mem_addr(idx), $random(seed));
   endtask

   task automatic build_table();
      int             pos_single[7] = '{1, 3, 32, 39, 2, 20, 38};
      int             pos_double[3] = '{1, 7, 38};
      ccm_pkg::addr_t bad_addr[5];
      int             i;
      bad_addr = '{ccm_pkg::CCM_BASE + 32'h10C, ccm_pkg::CCM_BASE + 32'h0E,
                   ccm_pkg::REG_BASE + 32'h8, ccm_pkg::REG_BASE + 32'h2, 32'h1000_000C};
      for (i = 0; i < 5; i++) add_mem_write(1, 3 + 15 * i);
      for (i = 0; i < 5; i++) add_read(1, mem_addr(3 + 15 * i));
      add_read(1, STATUS_ADDR);
      for (i = 0; i < 7; i++) begin
         add_write(2, INJECT_ADDR, 32'h100 | pos_single[i]);
         add_mem_write(2, 8 + i);
         add_read(2, mem_addr(8 + i));
      end
      add_read(2, mem_addr(14));            // no scrub, counts again
      add_read(2, STATUS_ADDR);
      for (i = 0; i < 3; i++) begin
         add_write(3, INJECT_ADDR, 32'h200 | pos_double[i]);
         add_mem_write(3, 20 + i);
         add_read(3, mem_addr(20 + i));
      end
      add_read(3, STATUS_ADDR);
      add_write(4, INJECT_ADDR, 32'h0000_FF27);
      add_read(4, INJECT_ADDR);
      add_write(4, INJECT_ADDR, 32'h0000_010C);
      add_read(4, INJECT_ADDR);
      add_mem_write(4, 30);
      add_read(4, INJECT_ADDR);
      add_mem_write(4, 31);
      add_read(4, mem_addr(31));
      add_read(4, mem_addr(30));
      add_read(4, STATUS_ADDR);
      for (i = 0; i < 5; i++) begin
         add_write(5, bad_addr[i], 32'hFFFF_FFFF);
         add_read(5, bad_addr[i]);
      end
      add_read(5, mem_addr(3));             // aliases of the bad addresses
      add_read(5, INJECT_ADDR);
      add_read(5, STATUS_ADDR);
      add_write(6, STATUS_ADDR, 32'hFFFF_FFFF);
      add_read(6, STATUS_ADDR);
      add_write(6, INJECT_ADDR, 32'h0000_0105);
      add_mem_write(6, 40);
      add_read(6, mem_addr(40));
      add_read(6, STATUS_ADDR);
   endtask

   initial begin : main
      ccm_pkg::word_t rdata;
      logic           err;
      int             waits;
      int             i;
      int             test_checks;
      int             test_errors;
      rst_l   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      seed        = 62421;
      check_count = 0;
      error_count = 0;
      inj_model   = '0;
      cnt_single  = '0;
      cnt_double  = '0;
      test_name[1] = "clean write and read";
      test_name[2] = "single flip corrected";
      test_name[3] = "double flip flagged";
      test_name[4] = "inject register";
      test_name[5] = "rejected accesses";
      test_name[6] = "status clear";
      build_table();
      cycle_limit = rows.size() * 4 + 200;
      repeat (16) @(posedge clk);
      rst_l <= 1'b1;
      test_checks = 0;
      test_errors = 0;
      for (i = 0; i < rows.size(); i++) begin
         apb_transfer(rows[i].write, rows[i].addr, rows[i].wdata, rdata, err, waits);
         if (!rows[i].write) begin
            check_value("prdata", rows[i].exp_rdata, rdata);
         end
         check_value("pslverr", rows[i].exp_err, err);
         check_value("pready wait states", rows[i].exp_waits, waits);
         if (i == rows.size() - 1 || rows[i+1].test != rows[i].test) begin
            $display("test %0d %s: %0d checks, %0d errors", rows[i].test,
                     test_name[rows[i].test], check_count - test_checks,
                     error_count - test_errors);
            test_checks = check_count;
            test_errors = error_count;
         end
      end
      $display("summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // limit follows the table length, set before the first edge
   initial begin : watchdog
      cycle_count = 0;
      @(posedge clk);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+verification
hdl/ccm_pkg.sv
hdl/secded_encode.sv
hdl/secded_decode.sv
hdl/ccm_array.sv
hdl/ccm_apb_ctrl.sv
hdl/ccm_top.sv
verification/tb_ccm_top.sv
